// File: rtl/cpu_pkg.sv
/*
 shared types and constants for the pipelined core
 opcode/funct/alu encodings, instruction union, pipeline latch structs
 */
`default_nettype none

package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regbits_t;

   // supported opcodes, everything else decodes as a no-op
   typedef enum logic [5:0] {
      RTYPE = 6'h00,
      BEQ   = 6'h04,
      BNE   = 6'h05,
      ADDIU = 6'h09,
      ORI   = 6'h0d,
      LW    = 6'h23,
      SW    = 6'h2b,
      HALT  = 6'h3f
   } opcode_t;

   typedef enum logic [5:0] {
      ADDU = 6'h21,
      SUBU = 6'h23,
      AND  = 6'h24,
      OR   = 6'h25,
      SLT  = 6'h2a
   } funct_t;

   // ALU_ADD is zero so a cleared ctrl_t is a valid do-nothing
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } aluop_t;

   typedef enum logic [1:0] {
      FWD_NONE = 2'd0,
      FWD_MEM  = 2'd1,
      FWD_WB   = 2'd2
   } fwd_t;

   ////////////////////////////////////////////////////
   // instruction word, two views
   ////////////////////////////////////////////////////
   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      regbits_t rd;
      logic [4:0] shamt;
      funct_t   funct;
   } r_fields_t;

   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      logic [15:0] imm16;
   } i_fields_t;

   typedef union packed {
      r_fields_t r_fields;
      i_fields_t i_fields;
   } instr_u;

   // decoded control, travels down the pipe
   typedef struct packed {
      aluop_t alu_op;
      logic   alu_src_imm;
      logic   ext_sign;
      logic   reg_wr;
      logic   wsel_rt;
      logic   mem_rd;
      logic   mem_wr;
      logic   mem_to_reg;
      logic   branch_eq;
      logic   branch_ne;
      logic   halt;
   } ctrl_t;

   ////////////////////////////////////////////////////
   // pipeline latches
   ////////////////////////////////////////////////////
   typedef struct packed {
      instr_u instr;
      word_t  pc_plus_4;
   } fd_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    pc_plus_4;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm_ext;
      regbits_t rs;
      regbits_t rt;
      regbits_t wsel;
   } de_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    alu_res;
      word_t    store_dat;
      regbits_t wsel;
   } em_t;

   typedef struct packed {
      logic     reg_wr;
      logic     halt;
      logic     mem_to_reg;
      word_t    alu_res;
      word_t    load_dat;
      regbits_t wsel;
   } mw_t;

   localparam word_t PC_INIT   = 32'h0000_0000;
   localparam word_t NOP_INSTR = 32'h0000_0000;

endpackage

`default_nettype wire

// File: rtl/cpu_ifs.sv
/*
 mem_port_if: instruction/data memory traffic and halt
 hazard_if: datapath to hazard unit, stalls, flushes, forwarding
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
   // instruction side
   cpu_pkg::word_t imem_addr;
   logic           imem_ren;
   cpu_pkg::word_t imem_load;
   logic           ihit;
   // data side
   cpu_pkg::word_t dmem_addr;
   logic           dmem_ren;
   logic           dmem_wen;
   cpu_pkg::word_t dmem_store;
   cpu_pkg::word_t dmem_load;
   logic           dhit;
   logic           halt;

   modport dp (
      output imem_addr, imem_ren, dmem_addr, dmem_ren, dmem_wen, dmem_store, halt,
      input  imem_load, ihit, dmem_load, dhit
   );

   modport core (
      input  imem_addr, imem_ren, dmem_addr, dmem_ren, dmem_wen, dmem_store, halt,
      output imem_load, ihit, dmem_load, dhit
   );
endinterface

interface hazard_if;
   // stage state from the datapath
   cpu_pkg::regbits_t fd_rs, fd_rt;
   cpu_pkg::regbits_t de_rs, de_rt;
   logic              de_mem_rd;
   cpu_pkg::regbits_t em_wsel, mw_wsel;
   logic              em_reg_wr, mw_reg_wr;
   logic              br_taken;
   logic              ihit, dhit, dmem_pend;
   logic              halt;
   // pipeline steering
   logic              fd_en, fd_flush, de_en, de_flush, em_en, mw_en, pc_en;
   cpu_pkg::fwd_t     fwd_a, fwd_b;

   modport dp (
      output fd_rs, fd_rt, de_rs, de_rt, de_mem_rd, em_wsel, mw_wsel,
             em_reg_wr, mw_reg_wr, br_taken, ihit, dhit, dmem_pend, halt,
      input  fd_en, fd_flush, de_en, de_flush, em_en, mw_en, pc_en, fwd_a, fwd_b
   );

   modport unit (
      input  fd_rs, fd_rt, de_rs, de_rt, de_mem_rd, em_wsel, mw_wsel,
             em_reg_wr, mw_reg_wr, br_taken, ihit, dhit, dmem_pend, halt,
      output fd_en, fd_flush, de_en, de_flush, em_en, mw_en, pc_en, fwd_a, fwd_b
   );
endinterface

`default_nettype wire

// File: rtl/control_unit.sv
/*
 instruction decoder, fetched word to control fields
 */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
   input  cpu_pkg::instr_u instr,
   output cpu_pkg::ctrl_t  ctrl
);

   always_comb begin
      // everything off unless an opcode below claims it
      ctrl = '0;
      case (instr.i_fields.opcode)
         cpu_pkg::RTYPE: begin
            ctrl.reg_wr = 1'b1;
            // funct only means something in the R view
            case (instr.r_fields.funct)
               cpu_pkg::ADDU: ctrl.alu_op = cpu_pkg::ALU_ADD;
               cpu_pkg::SUBU: ctrl.alu_op = cpu_pkg::ALU_SUB;
               cpu_pkg::AND:  ctrl.alu_op = cpu_pkg::ALU_AND;
               cpu_pkg::OR:   ctrl.alu_op = cpu_pkg::ALU_OR;
               cpu_pkg::SLT:  ctrl.alu_op = cpu_pkg::ALU_SLT;
               default:       ctrl = '0;
            endcase
         end
         cpu_pkg::ADDIU: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.ext_sign    = 1'b1;
            ctrl.reg_wr      = 1'b1;
            ctrl.wsel_rt     = 1'b1;
         end
         cpu_pkg::ORI: begin
            // zero-extended immediate
            ctrl.alu_op      = cpu_pkg::ALU_OR;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_wr      = 1'b1;
            ctrl.wsel_rt     = 1'b1;
         end
         cpu_pkg::LW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.ext_sign    = 1'b1;
            ctrl.reg_wr      = 1'b1;
            ctrl.wsel_rt     = 1'b1;
            ctrl.mem_rd      = 1'b1;
            ctrl.mem_to_reg  = 1'b1;
         end
         cpu_pkg::SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.ext_sign    = 1'b1;
            ctrl.mem_wr      = 1'b1;
         end
         // branch offset is signed, compare done on forwarded operands
         cpu_pkg::BEQ: {ctrl.ext_sign, ctrl.branch_eq} = 2'b11;
         cpu_pkg::BNE: {ctrl.ext_sign, ctrl.branch_ne} = 2'b11;
         cpu_pkg::HALT: ctrl.halt = 1'b1;
         default: ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/register_file.sv
/*
 32 x 32 register file, r0 fixed at zero, write-through read bypass
 */
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  logic              CLK,
   input  logic              nRST,
   input  cpu_pkg::regbits_t rsel1,
   input  cpu_pkg::regbits_t rsel2,
   input  cpu_pkg::regbits_t wsel,
   input  logic              wen,
   input  cpu_pkg::word_t    wdat,
   output cpu_pkg::word_t    rdat1,
   output cpu_pkg::word_t    rdat2
);
   cpu_pkg::word_t regs [32];
   logic           wr_live;

   // r0 never takes a write
   assign wr_live = wen && (wsel != '0);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         regs <= '{default: '0};
      end else if (wr_live) begin
         regs[wsel] <= wdat;
      end
   end

   // same-cycle writeback visible to decode
   assign rdat1 = (wr_live && (wsel == rsel1)) ? wdat : regs[rsel1];
   assign rdat2 = (wr_live && (wsel == rsel2)) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

// File: rtl/alu.sv
/*
 ALU for the supported subset
 */
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  cpu_pkg::aluop_t op,
   input  cpu_pkg::word_t  a,
   input  cpu_pkg::word_t  b,
   output cpu_pkg::word_t  res
);

   always_comb begin
      case (op)
         cpu_pkg::ALU_ADD: res = a + b;
         cpu_pkg::ALU_SUB: res = a - b;
         cpu_pkg::ALU_AND: res = a & b;
         cpu_pkg::ALU_OR:  res = a | b;
         // signed compare, result in bit 0
         cpu_pkg::ALU_SLT: res = {31'b0, $signed(a) < $signed(b)};
         default:          res = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
/*
 stall and flush control plus forwarding selects
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   hazard_if.unit hz
);
   logic mem_stall;
   logic load_use;

   // newest producer wins and r0 is never forwarded
   function automatic cpu_pkg::fwd_t fwd_pick(cpu_pkg::regbits_t src);
      if (hz.em_reg_wr && (hz.em_wsel != '0) && (hz.em_wsel == src))
         return cpu_pkg::FWD_MEM;
      if (hz.mw_reg_wr && (hz.mw_wsel != '0) && (hz.mw_wsel == src))
         return cpu_pkg::FWD_WB;
      return cpu_pkg::FWD_NONE;
   endfunction

   // whole pipe holds while a data access waits
   assign mem_stall = hz.dmem_pend & ~hz.dhit;

   // load in EX feeding the instruction in ID
   assign load_use = hz.de_mem_rd && (hz.de_rt != '0) &&
                     ((hz.de_rt == hz.fd_rs) || (hz.de_rt == hz.fd_rt));

   ////////////////////////////////////////////////////
   // enables and flushes
   ////////////////////////////////////////////////////
   assign hz.em_en = ~mem_stall;
   assign hz.mw_en = ~mem_stall;
   assign hz.de_en = ~mem_stall;
   assign hz.fd_en = ~mem_stall & ~load_use;

   // bubble into EX on load-use
   // wrong path killed on a taken branch
   assign hz.de_flush = ~mem_stall & (hz.br_taken | load_use | hz.halt);
   // bubble into ID while fetch waits
   assign hz.fd_flush = ~mem_stall & (hz.br_taken | hz.halt | (~hz.ihit & ~load_use));

   // taken branch redirects even without ihit
   assign hz.pc_en = ~mem_stall & ~hz.halt & (hz.br_taken | (hz.ihit & ~load_use));

   // forwarding selects for both ALU operands
   always_comb begin
      hz.fwd_a = fwd_pick(hz.de_rs);
      hz.fwd_b = fwd_pick(hz.de_rt);
   end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
/*
 five-stage datapath: PC, pipeline latches, forwarding and ALU-source muxes
 immediate extender, branch resolution in EX, writeback select, halt latch
 */
`timescale 1ns/1ps
`default_nettype none

module datapath (
   input  logic   CLK,
   input  logic   nRST,
   mem_port_if.dp mem
);
   cpu_pkg::word_t    pc;
   cpu_pkg::word_t    pc_plus_4;
   cpu_pkg::fd_t      fd;
   cpu_pkg::de_t      de;
   cpu_pkg::em_t      em;
   cpu_pkg::mw_t      mw;
   cpu_pkg::de_t      de_in;
   cpu_pkg::em_t      em_in;
   cpu_pkg::mw_t      mw_in;
   cpu_pkg::ctrl_t    ctrl;
   cpu_pkg::word_t    rdat1, rdat2;
   cpu_pkg::word_t    op_a, op_b, alu_b, alu_res;
   cpu_pkg::word_t    br_target;
   cpu_pkg::word_t    wdat;
   logic              br_taken;
   logic              halting;

   // operand source, latched read data or a newer in-flight result
   function automatic cpu_pkg::word_t fwd_mux(cpu_pkg::fwd_t sel, cpu_pkg::word_t rdat,
                                              cpu_pkg::word_t mem_val,
                                              cpu_pkg::word_t wb_val);
      case (sel)
         cpu_pkg::FWD_MEM: return mem_val;
         cpu_pkg::FWD_WB:  return wb_val;
         default:          return rdat;
      endcase
   endfunction

   hazard_if hz ();

   control_unit u_control (.instr(fd.instr), .ctrl(ctrl));

   register_file u_regs (
      .CLK   (CLK),
      .nRST  (nRST),
      .rsel1 (fd.instr.r_fields.rs),
      .rsel2 (fd.instr.r_fields.rt),
      .wsel  (mw.wsel),
      .wen   (mw.reg_wr),
      .wdat  (wdat),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

   alu u_alu (.op(de.ctrl.alu_op), .a(op_a), .b(alu_b), .res(alu_res));

   hazard_unit u_hazard (.hz(hz));

   ////////////////////////////////////////////////////
   // fetch
   ////////////////////////////////////////////////////
   assign pc_plus_4     = pc + 32'd4;
   assign mem.imem_addr = pc;
   // halt committed once it reaches EX, fetch stops there
   assign halting       = de.ctrl.halt | em.ctrl.halt | mw.halt | mem.halt;
   assign mem.imem_ren  = ~halting;

   ////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////
   assign de_in.ctrl      = ctrl;
   assign de_in.pc_plus_4 = fd.pc_plus_4;
   assign de_in.rdat1     = rdat1;
   assign de_in.rdat2     = rdat2;
   // sign or zero extend
   assign de_in.imm_ext   = {{16{ctrl.ext_sign & fd.instr.i_fields.imm16[15]}},
                             fd.instr.i_fields.imm16};
   assign de_in.rs        = fd.instr.r_fields.rs;
   assign de_in.rt        = fd.instr.r_fields.rt;
   // I-type writes rt, R-type writes rd
   assign de_in.wsel      = ctrl.wsel_rt ? fd.instr.r_fields.rt : fd.instr.r_fields.rd;

   ////////////////////////////////////////////////////
   // execute
   ////////////////////////////////////////////////////
   assign op_a  = fwd_mux(hz.fwd_a, de.rdat1, em.alu_res, wdat);
   assign op_b  = fwd_mux(hz.fwd_b, de.rdat2, em.alu_res, wdat);
   assign alu_b = de.ctrl.alu_src_imm ? de.imm_ext : op_b;

   // branch resolves here, predicted not taken
   assign br_target = de.pc_plus_4 + {de.imm_ext[29:0], 2'b00};
   assign br_taken  = (de.ctrl.branch_eq & (op_a == op_b)) |
                      (de.ctrl.branch_ne & (op_a != op_b));

   assign em_in.ctrl      = de.ctrl;
   assign em_in.alu_res   = alu_res;
   // store data taken before the ALU-source mux
   assign em_in.store_dat = op_b;
   assign em_in.wsel      = de.wsel;

   ////////////////////////////////////////////////////
   // memory and writeback
   ////////////////////////////////////////////////////
   assign mem.dmem_addr  = em.alu_res;
   assign mem.dmem_ren   = em.ctrl.mem_rd;
   assign mem.dmem_wen   = em.ctrl.mem_wr;
   assign mem.dmem_store = em.store_dat;

   assign mw_in.reg_wr     = em.ctrl.reg_wr;
   assign mw_in.halt       = em.ctrl.halt;
   assign mw_in.mem_to_reg = em.ctrl.mem_to_reg;
   assign mw_in.alu_res    = em.alu_res;
   assign mw_in.load_dat   = mem.dmem_load;
   assign mw_in.wsel       = em.wsel;

   assign wdat = mw.mem_to_reg ? mw.load_dat : mw.alu_res;

   // hazard unit view of the pipe
   assign hz.fd_rs     = fd.instr.r_fields.rs;
   assign hz.fd_rt     = fd.instr.r_fields.rt;
   assign hz.de_rs     = de.rs;
   assign hz.de_rt     = de.rt;
   assign hz.de_mem_rd = de.ctrl.mem_rd;
   assign hz.em_wsel   = em.wsel;
   assign hz.em_reg_wr = em.ctrl.reg_wr;
   assign hz.mw_wsel   = mw.wsel;
   assign hz.mw_reg_wr = mw.reg_wr;
   assign hz.br_taken  = br_taken;
   assign hz.ihit      = mem.ihit;
   assign hz.dhit      = mem.dhit;
   assign hz.dmem_pend = em.ctrl.mem_rd | em.ctrl.mem_wr;
   assign hz.halt      = halting;

   ////////////////////////////////////////////////////
   // PC and pipeline latches
   ////////////////////////////////////////////////////
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc <= cpu_pkg::PC_INIT;
         fd <= '{instr: cpu_pkg::NOP_INSTR, pc_plus_4: '0};
         de <= '0;
         em <= '0;
         mw <= '0;
      end else begin
         if (hz.pc_en)
            pc <= br_taken ? br_target : pc_plus_4;
         // flush wins over hold
         if (hz.fd_flush)
            fd <= '{instr: cpu_pkg::NOP_INSTR, pc_plus_4: '0};
         else if (hz.fd_en)
            fd <= '{instr: mem.imem_load, pc_plus_4: pc_plus_4};
         if (hz.de_flush)
            de <= '0;
         else if (hz.de_en)
            de <= de_in;
         if (hz.em_en)
            em <= em_in;
         if (hz.mw_en)
            mw <= mw_in;
      end
   end

   // sticky until reset
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         mem.halt <= 1'b0;
      else if (mw.halt)
         mem.halt <= 1'b1;
   end

endmodule

`default_nettype wire

// File: rtl/cpu_core.sv
/*
 core top level, plain memory ports around the datapath
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
   input  logic           CLK,
   input  logic           nRST,
   output cpu_pkg::word_t imem_addr,
   output logic           imem_ren,
   input  cpu_pkg::word_t imem_load,
   input  logic           ihit,
   output cpu_pkg::word_t dmem_addr,
   output logic           dmem_ren,
   output logic           dmem_wen,
   output cpu_pkg::word_t dmem_store,
   input  cpu_pkg::word_t dmem_load,
   input  logic           dhit,
   output logic           halt
);
   mem_port_if mp ();

   // instruction side
   assign imem_addr    = mp.imem_addr;
   assign imem_ren     = mp.imem_ren;
   assign mp.imem_load = imem_load;
   assign mp.ihit      = ihit;

   // data side
   assign dmem_addr    = mp.dmem_addr;
   assign dmem_ren     = mp.dmem_ren;
   assign dmem_wen     = mp.dmem_wen;
   assign dmem_store   = mp.dmem_store;
   assign mp.dmem_load = dmem_load;
   assign mp.dhit      = dhit;
   assign halt         = mp.halt;

   datapath u_datapath (.CLK(CLK), .nRST(nRST), .mem(mp));

endmodule

`default_nettype wire

// File: verification/cpu_props.sv
/*
 memory-port protocol and halt assertions, bound into the datapath
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_props (
   input logic CLK,
   input logic nRST,
   input logic imem_ren,
   input logic dmem_ren,
   input logic dmem_wen,
   input logic dhit,
   input logic halt
);

   // one data access at a time
   a_no_rd_wr: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_ren && dmem_wen)) else $error("dmem_ren and dmem_wen both high");

   // data enables wait for their hit
   a_ren_hold: assert property (@(posedge CLK) disable iff (!nRST)
      (dmem_ren && !dhit) |=> dmem_ren) else $error("dmem_ren dropped before dhit");
   a_wen_hold: assert property (@(posedge CLK) disable iff (!nRST)
      (dmem_wen && !dhit) |=> dmem_wen) else $error("dmem_wen dropped before dhit");

   // halt is sticky and quiets the ports
   a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      halt |=> halt) else $error("halt fell without reset");
   a_halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
      halt |-> !(imem_ren || dmem_ren || dmem_wen)) else $error("enable raised after halt");

endmodule

`default_nettype wire

// File: verification/tb_cpu.sv
/*
 testbench for cpu_core with memory models and random waits
 program builder, instruction-level reference model, store checker and cycle limit
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
   logic           CLK = 1'b0;
   logic           nRST = 1'b0;
   cpu_pkg::word_t imem_addr, dmem_addr, dmem_store, imem_load, dmem_load;
   logic           imem_ren, dmem_ren, dmem_wen, halt;
   logic           ihit = 1'b0;
   logic           dhit = 1'b0;

   cpu_pkg::word_t imem [256];
   cpu_pkg::word_t dmem [256];
   cpu_pkg::word_t ref_mem [256];
   cpu_pkg::word_t exp_addr [$];
   cpu_pkg::word_t exp_data [$];
   int             prog_len, store_idx, cycles, limit, n_exec;
   int unsigned    iwait, dwait;

   cpu_core uut (
      .CLK(CLK), .nRST(nRST), .imem_addr(imem_addr), .imem_ren(imem_ren),
      .imem_load(imem_load), .ihit(ihit), .dmem_addr(dmem_addr), .dmem_ren(dmem_ren),
      .dmem_wen(dmem_wen), .dmem_store(dmem_store), .dmem_load(dmem_load),
      .dhit(dhit), .halt(halt)
   );

   bind datapath cpu_props u_props (
      .CLK(CLK), .nRST(nRST), .imem_ren(mem.imem_ren), .dmem_ren(mem.dmem_ren),
      .dmem_wen(mem.dmem_wen), .dhit(mem.dhit), .halt(mem.halt)
   );

   always #50 CLK = ~CLK;

   // word-addressed memory read ports
   assign imem_load = imem[imem_addr[9:2]];
   assign dmem_load = dmem[dmem_addr[9:2]];

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(string name, cpu_pkg::word_t got, cpu_pkg::word_t exp);
      if (got !== exp)
         fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   task automatic check_count(string name, int got, int exp);
      if (got != exp)
         fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
   endtask

   // initial data memory contents
   function automatic cpu_pkg::word_t fill_word(int i);
      return (i * 32'h9e37_79b1) ^ {i[15:0], ~i[15:0]};
   endfunction

   function automatic cpu_pkg::word_t enc_r(cpu_pkg::funct_t fn, int rd, int rs, int rt);
      return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
   endfunction

   function automatic cpu_pkg::word_t enc_i(cpu_pkg::opcode_t op, int rt, int rs,
                                            logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   task automatic emit(cpu_pkg::word_t w);
      imem[prog_len] = w;
      prog_len++;
   endtask

   //////////////////////////////////////////////////
   // instruction-level reference model
   //////////////////////////////////////////////////
   function automatic int run_iss();
      cpu_pkg::word_t regs [32];
      cpu_pkg::word_t pc, nxt, w, se, ea;
      logic [5:0]     op, fn;
      int             rs, rt, rd, steps;
      regs = '{default: '0};
      pc = cpu_pkg::PC_INIT;
      steps = 0;
      exp_addr.delete();
      exp_data.delete();
      for (int i = 0; i < 256; i++)
         ref_mem[i] = fill_word(i);
      while (steps < 1000) begin
         w = imem[pc[9:2]];
         op = w[31:26];
         fn = w[5:0];
         rs = w[25:21];
         rt = w[20:16];
         rd = w[15:11];
         se = {{16{w[15]}}, w[15:0]};
         ea = regs[rs] + se;
         nxt = pc + 4;
         steps++;
         if (op == cpu_pkg::HALT)
            break;
         case (op)
            cpu_pkg::RTYPE: case (fn)
               cpu_pkg::ADDU: regs[rd] = regs[rs] + regs[rt];
               cpu_pkg::SUBU: regs[rd] = regs[rs] - regs[rt];
               cpu_pkg::AND:  regs[rd] = regs[rs] & regs[rt];
               cpu_pkg::OR:   regs[rd] = regs[rs] | regs[rt];
               cpu_pkg::SLT:  regs[rd] = {31'b0, $signed(regs[rs]) < $signed(regs[rt])};
               default: ;
            endcase
            cpu_pkg::ADDIU: regs[rt] = ea;
            cpu_pkg::ORI:   regs[rt] = regs[rs] | {16'h0, w[15:0]};
            cpu_pkg::LW:    regs[rt] = ref_mem[ea[9:2]];
            cpu_pkg::SW: begin
               ref_mem[ea[9:2]] = regs[rt];
               exp_addr.push_back(ea);
               exp_data.push_back(regs[rt]);
            end
            cpu_pkg::BEQ: if (regs[rs] == regs[rt]) nxt = pc + 4 + {se[29:0], 2'b00};
            cpu_pkg::BNE: if (regs[rs] != regs[rt]) nxt = pc + 4 + {se[29:0], 2'b00};
            default: ;
         endcase
         regs[0] = '0;
         pc = nxt;
      end
      return steps;
   endfunction

   // hand-assembled programs with random immediates
   task automatic build_program(int which);
      logic [15:0] a, b, c;
      a = 16'($urandom());
      b = 16'($urandom());
      c = 16'($urandom());
      imem = '{default: cpu_pkg::NOP_INSTR};
      prog_len = 0;
      case (which)
         // arithmetic with forwarding at distance one and two
         0: begin
            emit(enc_i(cpu_pkg::ADDIU, 1, 0, a));
            emit(enc_i(cpu_pkg::ORI, 2, 0, b));
            emit(enc_r(cpu_pkg::ADDU, 3, 1, 2));
            emit(enc_r(cpu_pkg::SUBU, 4, 3, 1));
            emit(enc_r(cpu_pkg::AND, 5, 4, 2));
            emit(enc_r(cpu_pkg::OR, 6, 5, 3));
            emit(enc_r(cpu_pkg::SLT, 7, 1, 2));
            emit(enc_r(cpu_pkg::SLT, 8, 2, 1));
            for (int r = 3; r <= 8; r++)
               emit(enc_i(cpu_pkg::SW, r, 0, 16'h0100 + 16'(4 * r)));
            emit(enc_i(cpu_pkg::ADDIU, 9, 1, c));
            emit(enc_i(cpu_pkg::SW, 9, 0, 16'h0124));
         end
         // load-use and register zero
         1: begin
            emit(enc_i(cpu_pkg::ADDIU, 1, 0, a));
            emit(enc_i(cpu_pkg::SW, 1, 0, 16'h0140));
            emit(enc_i(cpu_pkg::LW, 2, 0, 16'h0140));
            emit(enc_r(cpu_pkg::ADDU, 3, 2, 2));
            emit(enc_i(cpu_pkg::SW, 3, 0, 16'h0144));
            emit(enc_i(cpu_pkg::LW, 4, 0, 16'h0180));
            emit(enc_i(cpu_pkg::SW, 4, 0, 16'h0148));
            emit(enc_i(cpu_pkg::ORI, 0, 0, b));
            emit(enc_i(cpu_pkg::SW, 0, 0, 16'h014c));
            emit(enc_r(cpu_pkg::ADDU, 0, 1, 1));
            emit(enc_r(cpu_pkg::OR, 5, 0, 1));
            emit(enc_i(cpu_pkg::SW, 5, 0, 16'h0150));
         end
         // taken and not-taken branches with stores on the wrong path
         default: begin
            emit(enc_i(cpu_pkg::ADDIU, 1, 0, a));
            emit(enc_i(cpu_pkg::ADDIU, 2, 0, a));
            emit(enc_i(cpu_pkg::ADDIU, 3, 0, a ^ 16'h0010));
            emit(enc_i(cpu_pkg::BEQ, 2, 1, 16'd2));
            emit(enc_i(cpu_pkg::SW, 1, 0, 16'h0160));
            emit(enc_i(cpu_pkg::SW, 2, 0, 16'h0164));
            emit(enc_i(cpu_pkg::BNE, 2, 1, 16'd1));
            emit(enc_i(cpu_pkg::SW, 3, 0, 16'h0168));
            emit(enc_i(cpu_pkg::BNE, 3, 1, 16'd1));
            emit(enc_i(cpu_pkg::SW, 3, 0, 16'h016c));
            emit(enc_i(cpu_pkg::BEQ, 3, 1, 16'd1));
            emit(enc_i(cpu_pkg::SW, 1, 0, 16'h0170));
         end
      endcase
      emit({cpu_pkg::HALT, 26'd0});
   endtask

   //////////////////////////////////////////////////
   // memory wait model with a hit after 0 to 3 cycles
   //////////////////////////////////////////////////
   always @(posedge CLK) begin
      if (!nRST) begin
         ihit <= 1'b0;
         dhit <= 1'b0;
         iwait <= 0;
         dwait <= 0;
      end else begin
         if (imem_ren && iwait == 0) begin
            ihit <= 1'b1;
            iwait <= $urandom_range(3, 0);
         end else begin
            ihit <= 1'b0;
            if (imem_ren)
               iwait <= iwait - 1;
         end
         if ((dmem_ren || dmem_wen) && dwait == 0) begin
            dhit <= 1'b1;
            dwait <= $urandom_range(3, 0);
         end else begin
            dhit <= 1'b0;
            if (dmem_ren || dmem_wen)
               dwait <= dwait - 1;
         end
      end
   end

   // store checker plus data memory writes and cycle limit
   always @(posedge CLK) begin
      if (!nRST) begin
         for (int i = 0; i < 256; i++)
            dmem[i] <= fill_word(i);
         store_idx <= 0;
         cycles <= 0;
      end else begin
         cycles <= cycles + 1;
         if (cycles > limit)
            fail_run("timeout: the core did not halt within the cycle limit");
         if (dmem_wen && dhit) begin
            if (store_idx >= exp_addr.size())
               fail_run("a store was taken when no further store was expected");
            check_word("dmem_addr", dmem_addr, exp_addr[store_idx]);
            check_word("dmem_store", dmem_store, exp_data[store_idx]);
            dmem[dmem_addr[9:2]] <= dmem_store;
            store_idx <= store_idx + 1;
         end
      end
   end

   initial begin
      void'($urandom(32'h623f));
      for (int p = 0; p < 3; p++) begin
         build_program(p);
         n_exec = run_iss();
         limit = n_exec * (4 + 3) + 200;
         @(posedge CLK);
         nRST <= 1'b0;
         repeat (10) @(posedge CLK);
         nRST <= 1'b1;
         while (halt !== 1'b1)
            @(posedge CLK);
         // quiet period after halt
         repeat (10) @(posedge CLK);
         check_count("store count", store_idx, exp_addr.size());
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
rtl/cpu_pkg.sv
rtl/cpu_ifs.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/datapath.sv
rtl/cpu_core.sv
verification/cpu_props.sv
verification/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_cpu \
   -f flist.f -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/vsim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with an error status"
   exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
   exit 0
fi
exit 1
